// ==== rtl/sm_pkg.sv ====
`default_nettype none

package sm_pkg;

  localparam int data_width    = 16;
  localparam int reg_idx_width = 3;
  localparam int imm_width     = 8;  // imm8 field, sign-extended to a word

  typedef logic [data_width-1:0]    word_t;
  typedef logic [reg_idx_width-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    op_alu  = 3'b101,
    op_move = 3'b110
  } opcode_e;

  // same order as the op field of alu instructions
  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_and = 2'b10,
    alu_not = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_none = 2'b00,
    sh_lsl  = 2'b01,
    sh_lsr  = 2'b10,
    sh_asr  = 2'b11
  } shift_e;

  typedef enum logic [1:0] {
    sel_rm = 2'b00,
    sel_rd = 2'b01,
    sel_rn = 2'b10
  } reg_sel_e;

  typedef enum logic {
    wb_result = 1'b0,
    wb_imm    = 1'b1
  } wb_sel_e;

  typedef enum logic [3:0] {
    st_idle,
    st_write_imm,
    st_load_b,
    st_load_a,
    st_exec,
    st_compare,
    st_write_rd
  } state_e;

endpackage

`default_nettype wire

// ==== rtl/sm_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_regfile (
  input  logic             clk,
  input  logic             w_en,
  input  sm_pkg::reg_idx_t w_idx,
  input  sm_pkg::word_t    w_data,
  input  sm_pkg::reg_idx_t r_idx,
  output sm_pkg::word_t    r_data
);

  localparam int num_regs = 2 ** sm_pkg::reg_idx_width;

  sm_pkg::word_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (w_en) begin
      regs[w_idx] <= w_data;
    end
  end

  assign r_data = regs[r_idx];  // async read

endmodule

`default_nettype wire

// ==== rtl/sm_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_alu (
  input  sm_pkg::word_t   a,
  input  sm_pkg::word_t   b,
  input  sm_pkg::alu_op_e alu_op,
  output sm_pkg::word_t   y,
  output logic            z,
  output logic            n,
  output logic            v
);

  localparam int msb = sm_pkg::data_width - 1;

  logic          sub;
  sm_pkg::word_t b_inv;
  sm_pkg::word_t sum;

  assign sub   = (alu_op == sm_pkg::alu_sub);
  assign b_inv = sub ? ~b : b;
  assign sum   = a + b_inv + sm_pkg::word_t'(sub);  // two's complement subtract

  always_comb begin
    case (alu_op)
      sm_pkg::alu_and: y = a & b;
      sm_pkg::alu_not: y = ~b;
      default:         y = sum;
    endcase
  end

  assign z = (y == '0);
  assign n = y[msb];

  // operands of equal sign giving a result of the other sign
  assign v = (alu_op == sm_pkg::alu_add || sub) &&
             (a[msb] == b_inv[msb]) && (sum[msb] != a[msb]);

endmodule

`default_nettype wire

// ==== rtl/sm_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_decoder (
  input  sm_pkg::word_t    ir,
  input  sm_pkg::reg_sel_e reg_sel,
  output sm_pkg::opcode_e  opcode,
  output logic [1:0]       op,
  output sm_pkg::shift_e   shift,
  output sm_pkg::reg_idx_t reg_idx,
  output sm_pkg::word_t    imm
);

  localparam int ext_width = sm_pkg::data_width - sm_pkg::imm_width;

  sm_pkg::reg_idx_t rm;
  sm_pkg::reg_idx_t rd;
  sm_pkg::reg_idx_t rn;

  assign opcode = sm_pkg::opcode_e'(ir[15:13]);
  assign op     = ir[12:11];
  assign shift  = sm_pkg::shift_e'(ir[4:3]);

  assign rn = ir[10:8];
  assign rd = ir[7:5];
  assign rm = ir[2:0];

  // replicate bit 7 into the upper byte
  assign imm = {{ext_width{ir[sm_pkg::imm_width-1]}}, ir[sm_pkg::imm_width-1:0]};

  // one index serves both the read and the write port
  always_comb begin
    case (reg_sel)
      sm_pkg::sel_rd: reg_idx = rd;
      sm_pkg::sel_rn: reg_idx = rn;
      default:        reg_idx = rm;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/sm_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_sequencer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  output logic             instr_ready,
  input  sm_pkg::word_t    instr,
  input  sm_pkg::opcode_e  opcode,
  input  logic [1:0]       op,
  output sm_pkg::word_t    ir,
  output sm_pkg::reg_sel_e reg_sel,
  output logic             w_en,
  output logic             en_a,
  output logic             en_b,
  output logic             en_c,
  output logic             en_status,
  output logic             zero_a,
  output sm_pkg::alu_op_e  alu_op,
  output sm_pkg::wb_sel_e  wb_sel,
  output logic             done
);

  sm_pkg::state_e state;
  sm_pkg::state_e state_nxt;
  sm_pkg::word_t  ir_q;

  assign instr_ready = (state == sm_pkg::st_idle);

  // decoder looks at the incoming word while idle
  assign ir = instr_ready ? instr : ir_q;

  always_ff @(posedge clk) begin
    if (instr_valid && instr_ready) begin
      ir_q <= instr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= sm_pkg::st_idle;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= (state != sm_pkg::st_idle) && (state_nxt == sm_pkg::st_idle);
    end
  end

  always_comb begin
    state_nxt = sm_pkg::st_idle;
    case (state)
      sm_pkg::st_idle: begin
        if (instr_valid) begin
          if (opcode == sm_pkg::op_move && op == 2'b10) begin
            state_nxt = sm_pkg::st_write_imm;  // mov immediate
          end else if (opcode == sm_pkg::op_move && op == 2'b00) begin
            state_nxt = sm_pkg::st_load_b;
          end else if (opcode == sm_pkg::op_alu) begin
            state_nxt = sm_pkg::st_load_b;
          end
        end
      end
      sm_pkg::st_load_b: begin
        // mov and mvn need no rn
        if (opcode == sm_pkg::op_move || op == 2'b11) begin
          state_nxt = sm_pkg::st_exec;
        end else begin
          state_nxt = sm_pkg::st_load_a;
        end
      end
      sm_pkg::st_load_a: begin
        state_nxt = (op == 2'b01) ? sm_pkg::st_compare : sm_pkg::st_exec;
      end
      sm_pkg::st_exec: state_nxt = sm_pkg::st_write_rd;
      default:         state_nxt = sm_pkg::st_idle;  // last state of every chain
    endcase
  end

  always_comb begin
    reg_sel   = sm_pkg::sel_rm;
    w_en      = 1'b0;
    en_a      = 1'b0;
    en_b      = 1'b0;
    en_c      = 1'b0;
    en_status = 1'b0;
    zero_a    = 1'b0;
    alu_op    = sm_pkg::alu_add;
    wb_sel    = sm_pkg::wb_result;
    case (state)
      sm_pkg::st_write_imm: begin
        reg_sel = sm_pkg::sel_rn;
        wb_sel  = sm_pkg::wb_imm;
        w_en    = 1'b1;
      end
      sm_pkg::st_load_b: en_b = 1'b1;
      sm_pkg::st_load_a: begin
        reg_sel = sm_pkg::sel_rn;
        en_a    = 1'b1;
      end
      sm_pkg::st_exec: begin
        en_c = 1'b1;
        if (opcode == sm_pkg::op_move) begin
          zero_a = 1'b1;  // 0 + shifted rm
        end else begin
          case (op)
            2'b10:   alu_op = sm_pkg::alu_and;
            2'b11:   alu_op = sm_pkg::alu_not;
            default: alu_op = sm_pkg::alu_add;
          endcase
        end
      end
      sm_pkg::st_compare: begin
        alu_op    = sm_pkg::alu_sub;
        en_status = 1'b1;
      end
      sm_pkg::st_write_rd: begin
        reg_sel = sm_pkg::sel_rd;
        w_en    = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/sm_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_datapath (
  input  logic             clk,
  input  logic             rst_n,
  input  sm_pkg::reg_idx_t reg_idx,
  input  sm_pkg::word_t    imm,
  input  sm_pkg::shift_e   shift,
  input  logic             w_en,
  input  logic             en_a,
  input  logic             en_b,
  input  logic             en_c,
  input  logic             en_status,
  input  logic             zero_a,
  input  sm_pkg::alu_op_e  alu_op,
  input  sm_pkg::wb_sel_e  wb_sel,
  output sm_pkg::word_t    result,
  output logic             z,
  output logic             n,
  output logic             v
);

  localparam int msb = sm_pkg::data_width - 1;

  sm_pkg::word_t r_data;
  sm_pkg::word_t w_data;
  sm_pkg::word_t reg_a;
  sm_pkg::word_t reg_b;
  sm_pkg::word_t val_a;
  sm_pkg::word_t val_b;
  sm_pkg::word_t alu_y;
  logic          alu_z;
  logic          alu_n;
  logic          alu_v;

  sm_regfile i_sm_regfile (
    .clk    (clk),
    .w_en   (w_en),
    .w_idx  (reg_idx),
    .w_data (w_data),
    .r_idx  (reg_idx),
    .r_data (r_data)
  );

  always_ff @(posedge clk) begin
    if (en_a) reg_a <= r_data;
    if (en_b) reg_b <= r_data;
  end

  always_comb begin
    case (shift)
      sm_pkg::sh_lsl: val_b = {reg_b[msb-1:0], 1'b0};
      sm_pkg::sh_lsr: val_b = {1'b0, reg_b[msb:1]};
      sm_pkg::sh_asr: val_b = {reg_b[msb], reg_b[msb:1]};  // keep sign
      default:        val_b = reg_b;
    endcase
  end

  assign val_a = zero_a ? '0 : reg_a;

  sm_alu i_sm_alu (
    .a      (val_a),
    .b      (val_b),
    .alu_op (alu_op),
    .y      (alu_y),
    .z      (alu_z),
    .n      (alu_n),
    .v      (alu_v)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
      {z, n, v} <= 3'b000;
    end else begin
      if (en_c) result <= alu_y;
      if (en_status) {z, n, v} <= {alu_z, alu_n, alu_v};
    end
  end

  assign w_data = (wb_sel == sm_pkg::wb_imm) ? imm : result;  // writeback mux

endmodule

`default_nettype wire

// ==== rtl/sm_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_cpu (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          instr_valid,
  output logic          instr_ready,
  input  sm_pkg::word_t instr,
  output sm_pkg::word_t result,
  output logic          z,
  output logic          n,
  output logic          v,
  output logic          done
);

  sm_pkg::word_t    ir;
  sm_pkg::reg_sel_e reg_sel;
  sm_pkg::opcode_e  opcode;
  logic [1:0]       op;
  sm_pkg::shift_e   shift;
  sm_pkg::reg_idx_t reg_idx;
  sm_pkg::word_t    imm;
  logic             w_en;
  logic             en_a;
  logic             en_b;
  logic             en_c;
  logic             en_status;
  logic             zero_a;
  sm_pkg::alu_op_e  alu_op;
  sm_pkg::wb_sel_e  wb_sel;

  sm_sequencer i_sm_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .opcode      (opcode),
    .op          (op),
    .ir          (ir),
    .reg_sel     (reg_sel),
    .w_en        (w_en),
    .en_a        (en_a),
    .en_b        (en_b),
    .en_c        (en_c),
    .en_status   (en_status),
    .zero_a      (zero_a),
    .alu_op      (alu_op),
    .wb_sel      (wb_sel),
    .done        (done)
  );

  sm_decoder i_sm_decoder (
    .ir      (ir),
    .reg_sel (reg_sel),
    .opcode  (opcode),
    .op      (op),
    .shift   (shift),
    .reg_idx (reg_idx),
    .imm     (imm)
  );

  sm_datapath i_sm_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_idx   (reg_idx),
    .imm       (imm),
    .shift     (shift),
    .w_en      (w_en),
    .en_a      (en_a),
    .en_b      (en_b),
    .en_c      (en_c),
    .en_status (en_status),
    .zero_a    (zero_a),
    .alu_op    (alu_op),
    .wb_sel    (wb_sel),
    .result    (result),
    .z         (z),
    .n         (n),
    .v         (v)
  );

endmodule

`default_nettype wire

// ==== verification/tb_sm_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sm_cpu;

  localparam int num_random = 300;
  localparam int max_cycles = 2000;  // ~355 words at about 4 cycles each plus gaps and margin

  logic        clk = 1'b0;
  logic        rst_n;
  logic        instr_valid;
  logic        instr_ready;
  logic [15:0] instr;
  logic [15:0] result;
  logic        z;
  logic        n;
  logic        v;
  logic        done;

  integer      seed;
  int          cycle_count = 0;
  logic [15:0] regs_m [8];  // reference model state
  logic [15:0] c_m;
  logic        z_m;
  logic        n_m;
  logic        v_m;

  sm_cpu i_sm_cpu (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .result      (result),
    .z           (z),
    .n           (n),
    .v           (v),
    .done        (done)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
    end
  end

  function automatic logic [15:0] rand16();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [15:0] mov_imm(input logic [2:0] rn, input logic [7:0] imm);
    return {5'b11010, rn, imm};
  endfunction

  function automatic logic [15:0] mov_reg(input logic [2:0] rd, input logic [1:0] sh,
                                          input logic [2:0] rm);
    return {5'b11000, 3'b000, rd, sh, rm};  // rn bits unused
  endfunction

  function automatic logic [15:0] alu_instr(input logic [1:0] op, input logic [2:0] rn,
                                            input logic [2:0] rd, input logic [1:0] sh,
                                            input logic [2:0] rm);
    return {3'b101, op, rn, rd, sh, rm};
  endfunction

  function automatic bit is_supported(input logic [15:0] w);
    return (w[15:13] == 3'b101) ||
           (w[15:13] == 3'b110 && w[12:11] inside {2'b00, 2'b10});
  endfunction

  function automatic logic [15:0] shift_model(input logic [15:0] x, input logic [1:0] sh);
    case (sh)
      2'b01:   return {x[14:0], 1'b0};
      2'b10:   return {1'b0, x[15:1]};
      2'b11:   return {x[15], x[15:1]};  // sign kept
      default: return x;
    endcase
  endfunction

  // updates the model for one accepted word and returns 0 when no done is due
  task automatic apply_model(input logic [15:0] w, output int latency);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] diff;
    a       = regs_m[w[10:8]];
    b       = shift_model(regs_m[w[2:0]], w[4:3]);
    latency = 0;
    if (w[15:13] == 3'b110 && w[12:11] == 2'b10) begin
      regs_m[w[10:8]] = {{8{w[7]}}, w[7:0]};
      latency         = 1;
    end else if (w[15:13] == 3'b110 && w[12:11] == 2'b00) begin
      c_m             = b;
      regs_m[w[7:5]]  = b;
      latency         = 3;
    end else if (w[15:13] == 3'b101) begin
      case (w[12:11])
        2'b00: begin
          c_m     = a + b;
          latency = 4;
        end
        2'b01: begin
          diff    = a - b;
          z_m     = (diff == 16'd0);
          n_m     = diff[15];
          v_m     = (a[15] != b[15]) && (diff[15] != a[15]);
          latency = 3;
        end
        2'b10: begin
          c_m     = a & b;
          latency = 4;
        end
        default: begin
          c_m     = ~b;
          latency = 3;
        end
      endcase
      if (w[12:11] != 2'b01) begin
        regs_m[w[7:5]] = c_m;  // cmp writes no register
      end
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // done pulses for one cycle only
  task automatic idle_cycles(input int count);
    repeat (count) begin
      instr_valid = 1'b0;
      instr       = rand16();
      @(negedge clk);
      check_word("done", 16'd0, {15'd0, done});
      check_word("instr_ready", 16'd1, {15'd0, instr_ready});
    end
  endtask

  // starts on a falling edge with the core idle and ends on a falling edge
  task automatic send_instr(input logic [15:0] w);
    int latency;
    int cycles;
    check_word("instr_ready", 16'd1, {15'd0, instr_ready});
    instr_valid = 1'b1;
    instr       = w;
    apply_model(w, latency);
    @(negedge clk);  // accepting edge has passed
    instr_valid = 1'b0;
    instr       = rand16();  // core must hold its own copy
    cycles      = 0;
    if (latency == 0) begin
      check_word("done", 16'd0, {15'd0, done});
      check_word("instr_ready", 16'd1, {15'd0, instr_ready});
    end else begin
      while (done !== 1'b1) begin
        check_word("instr_ready", 16'd0, {15'd0, instr_ready});
        @(negedge clk);
        instr  = rand16();
        cycles = cycles + 1;
      end
      check_word("done latency", 16'(latency), 16'(cycles));
      check_word("instr_ready", 16'd1, {15'd0, instr_ready});
      check_word("result", c_m, result);
      check_word("z", {15'd0, z_m}, {15'd0, z});
      check_word("n", {15'd0, n_m}, {15'd0, n});
      check_word("v", {15'd0, v_m}, {15'd0, v});
    end
  endtask

  task automatic random_word(output logic [15:0] w);
    logic [15:0] r;
    logic [15:0] pick;
    r    = rand16();
    pick = rand16() % 16'd6;
    case (pick)
      16'd0:   w = {5'b11010, r[10:0]};
      16'd1:   w = {5'b11000, r[10:0]};
      default: w = {3'b101, r[12:0]};  // add, cmp, and, mvn
    endcase
  endtask

  task automatic unsupported_word(output logic [15:0] w);
    w = rand16();
    while (is_supported(w)) begin
      w = rand16();
    end
  endtask

  initial begin
    logic [15:0] w;
    logic [15:0] pick;
    seed        = 57408;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = 16'd0;
    c_m         = 16'd0;
    z_m         = 1'b0;
    n_m         = 1'b0;
    v_m         = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_word("instr_ready", 16'd1, {15'd0, instr_ready});
    check_word("done", 16'd0, {15'd0, done});
    check_word("result", 16'd0, result);
    check_word("flags", 16'd0, {13'd0, z, n, v});

    for (int i = 0; i < 8; i++) begin
      w = rand16();
      send_instr(mov_imm(3'(i), w[7:0]));
    end

    // each shift code on a fresh immediate
    for (int s = 0; s < 4; s++) begin
      w = rand16();
      send_instr(mov_imm(3'd0, w[7:0]));
      send_instr(mov_reg(3'(s + 1), 2'(s), 3'd0));
    end

    send_instr(mov_imm(3'd3, 8'hff));                  // -1
    send_instr(mov_reg(3'd4, 2'b10, 3'd3));            // 0x7fff
    send_instr(alu_instr(2'b01, 3'd4, 3'd0, 2'b00, 3'd3));  // max minus -1 overflows
    send_instr(alu_instr(2'b11, 3'd0, 3'd5, 2'b00, 3'd4));  // 0x8000
    send_instr(mov_imm(3'd6, 8'h01));
    send_instr(alu_instr(2'b01, 3'd5, 3'd0, 2'b00, 3'd6));  // min minus 1 overflows
    send_instr(alu_instr(2'b01, 3'd6, 3'd0, 2'b00, 3'd6));  // equal gives z
    send_instr(16'h0000);
    send_instr(alu_instr(2'b00, 3'd6, 3'd7, 2'b01, 3'd6));

    for (int i = 0; i < num_random; i++) begin
      pick = rand16();
      if (pick % 16'd10 == 16'd0) begin
        unsupported_word(w);
        send_instr(w);
      end
      random_word(w);
      idle_cycles(int'(rand16() % 16'd2));
      send_instr(w);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/sm_pkg.sv
rtl/sm_regfile.sv
rtl/sm_alu.sv
rtl/sm_decoder.sv
rtl/sm_sequencer.sv
rtl/sm_datapath.sv
rtl/sm_cpu.sv
verification/tb_sm_cpu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --top-module tb_sm_cpu -f flist.f -o tb_sm_cpu &&
  ./obj_dir/tb_sm_cpu | grep "RESULT: PASS" ||
  exit 1
